/* hdl/z_servo_pkg.sv */
package z_servo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Word widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W        = 32;
    localparam int CONFIG_ADDR_W = 32;
    localparam int CONFIG_DATA_W = 512;

    // Gain products before the fraction shift
    localparam int PRODUCT_W      = 64;
    // cp and ci are signed Q15.16
    localparam int GAIN_FRAC_BITS = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration map
    ////////////////////////////////////////////////////////////////////////////

    // Slots: setpoint, cp, ci, upper, lower
    localparam logic [CONFIG_ADDR_W-1:0] CONTROL_REG_ADDR = 32'd100;
    // Slots: signal offset, control offset, z reset, transfer mode
    localparam logic [CONFIG_ADDR_W-1:0] MODES_REG_ADDR   = 32'd101;

    // Transfer mode and options bits
    localparam int MODE_ENABLE_BIT = 0;
    localparam int MODE_HOLD_BIT   = 3;
    localparam int OPTION_HOLD_BIT = 0;

    // Strobe in to strobe out
    localparam int PIPE_LATENCY = 4;

endpackage

/* hdl/z_servo_configuration.sv */
`timescale 1ns/1ps

module z_servo_configuration
    import z_servo_pkg::*;
(
    input  logic                             aclk,
    input  logic                             rst_n,

    input  logic        [CONFIG_ADDR_W-1:0]  config_addr,
    input  logic        [CONFIG_DATA_W-1:0]  config_data,
    input  logic        [DATA_W-1:0]         options,

    output logic signed [DATA_W-1:0]         setpoint,
    output logic signed [DATA_W-1:0]         cp,
    output logic signed [DATA_W-1:0]         ci,
    output logic signed [DATA_W-1:0]         upper_bound,
    output logic signed [DATA_W-1:0]         lower_bound,

    output logic signed [DATA_W-1:0]         signal_offset,
    output logic signed [DATA_W-1:0]         control_offset,
    output logic signed [DATA_W-1:0]         z_reset,
    output logic                             servo_enable,
    output logic                             servo_hold
);

    // Full mode word, log and FCZ bits stay in here without function
    logic [DATA_W-1:0] r_transfer_mode;
    logic [DATA_W-1:0] r_options;

    ////////////////////////////////////////////////////////////////////////////
    // Register bank
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            setpoint        <= '0;
            cp              <= '0;
            ci              <= '0;
            upper_bound     <= '0;
            lower_bound     <= '0;
            signal_offset   <= '0;
            control_offset  <= '0;
            z_reset         <= '0;
            r_transfer_mode <= '0;
            r_options       <= '0;
        end
        else
        begin
            case (config_addr)
                CONTROL_REG_ADDR:
                begin
                    setpoint    <= config_data[0*DATA_W +: DATA_W];
                    cp          <= config_data[1*DATA_W +: DATA_W];
                    ci          <= config_data[2*DATA_W +: DATA_W];
                    upper_bound <= config_data[3*DATA_W +: DATA_W];
                    lower_bound <= config_data[4*DATA_W +: DATA_W];
                end

                MODES_REG_ADDR:
                begin
                    signal_offset   <= config_data[0*DATA_W +: DATA_W];
                    // Usually zero
                    control_offset  <= config_data[1*DATA_W +: DATA_W];
                    z_reset         <= config_data[2*DATA_W +: DATA_W];
                    r_transfer_mode <= config_data[3*DATA_W +: DATA_W];
                end

                default:
                begin
                    // Other addresses belong to other blocks
                end
            endcase

            // Options come from another clocked block, buffer once
            r_options <= options;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Mode decode
    ////////////////////////////////////////////////////////////////////////////

    assign servo_enable = r_transfer_mode[MODE_ENABLE_BIT];

    // Hold from the mode word or from the options word
    assign servo_hold = r_transfer_mode[MODE_HOLD_BIT] | r_options[OPTION_HOLD_BIT];

endmodule

/* hdl/z_servo_error_stage.sv */
`timescale 1ns/1ps

module z_servo_error_stage
    import z_servo_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic signed [DATA_W-1:0] sample,
    input  logic                     sample_valid,

    input  logic signed [DATA_W-1:0] signal_offset,
    input  logic signed [DATA_W-1:0] setpoint,

    output logic signed [DATA_W-1:0] error,
    output logic                     error_valid
);

    logic signed [DATA_W-1:0] difference;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 1, error against setpoint
    ////////////////////////////////////////////////////////////////////////////

    // Plain 32 bit wrap, no saturation here
    assign difference = sample - signal_offset - setpoint;

    // Error word only moves with a sample
    always_ff @(posedge aclk)
    begin
        if (sample_valid)
        begin
            error <= difference;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            error_valid <= 1'b0;
        end
        else
        begin
            error_valid <= sample_valid;
        end
    end

endmodule

/* hdl/z_servo_pi_stage.sv */
`timescale 1ns/1ps

module z_servo_pi_stage
    import z_servo_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic signed [DATA_W-1:0] error,
    input  logic                     error_valid,

    input  logic signed [DATA_W-1:0] cp,
    input  logic signed [DATA_W-1:0] ci,
    input  logic signed [DATA_W-1:0] upper_bound,
    input  logic signed [DATA_W-1:0] lower_bound,
    input  logic signed [DATA_W-1:0] z_reset,
    input  logic                     servo_enable,
    input  logic                     servo_hold,

    output logic signed [DATA_W-1:0] servo_value,
    output logic                     servo_valid
);

    // Upper bound is tested first
    function automatic logic signed [DATA_W-1:0] clamp(
        input logic signed [PRODUCT_W-1:0] value,
        input logic signed [DATA_W-1:0]    lo,
        input logic signed [DATA_W-1:0]    hi
    );
        logic signed [PRODUCT_W-1:0] lo_wide;
        logic signed [PRODUCT_W-1:0] hi_wide;
        lo_wide = lo;
        hi_wide = hi;
        if (value > hi_wide)
        begin
            return hi;
        end
        else if (value < lo_wide)
        begin
            return lo;
        end
        return value[DATA_W-1:0];
    endfunction

    logic signed [PRODUCT_W-1:0] r_p_product;
    logic signed [PRODUCT_W-1:0] r_i_product;
    logic                        r_product_valid;

    logic signed [DATA_W-1:0]    r_integrator;

    logic signed [PRODUCT_W-1:0] p_term;
    logic signed [PRODUCT_W-1:0] i_step;
    logic signed [PRODUCT_W-1:0] integrator_sum;
    logic signed [DATA_W-1:0]    integrator_next;
    logic signed [PRODUCT_W-1:0] servo_sum;
    logic signed [DATA_W-1:0]    servo_next;

    ////////////////////////////////////////////////////////////////////////////
    // Stage 2, gain products
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk)
    begin
        if (error_valid)
        begin
            r_p_product <= cp * error;
            r_i_product <= ci * error;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            r_product_valid <= 1'b0;
            servo_valid     <= 1'b0;
        end
        else
        begin
            r_product_valid <= error_valid;
            servo_valid     <= r_product_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stage 3, integrator and clamp
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        p_term         = r_p_product >>> GAIN_FRAC_BITS;
        i_step         = r_i_product >>> GAIN_FRAC_BITS;
        integrator_sum = PRODUCT_W'(r_integrator) + i_step;

        // Preset, freeze or accumulate
        if (!servo_enable)
            integrator_next = z_reset;
        else if (servo_hold)
            integrator_next = r_integrator;
        else
            integrator_next = clamp(integrator_sum, lower_bound, upper_bound);

        servo_sum = PRODUCT_W'(integrator_next) + p_term;

        if (!servo_enable)
            servo_next = z_reset;
        else
            servo_next = clamp(servo_sum, lower_bound, upper_bound);
    end

    // Integrator steps once per sample so bursts chain
    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            r_integrator <= '0;
        end
        else if (r_product_valid)
        begin
            r_integrator <= integrator_next;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (r_product_valid)
        begin
            servo_value <= servo_next;
        end
    end

    // Output stays inside the bounds that were live one cycle earlier
    assert property (@(posedge aclk) disable iff (!rst_n)
        (servo_valid && $past(servo_enable) && ($past(lower_bound) <= $past(upper_bound)))
        |-> (servo_value >= $past(lower_bound) && servo_value <= $past(upper_bound)))
        else $error("servo_value outside the configured bounds");

endmodule

/* hdl/z_servo_output_stage.sv */
`timescale 1ns/1ps

module z_servo_output_stage
    import z_servo_pkg::*;
(
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic signed [DATA_W-1:0] servo_value,
    input  logic                     servo_valid,

    input  logic signed [DATA_W-1:0] control_offset,

    output logic signed [DATA_W-1:0] control,
    output logic                     control_valid
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage 4, control signal offset
    ////////////////////////////////////////////////////////////////////////////

    // Wraps at 32 bits like the error stage
    always_ff @(posedge aclk)
    begin
        if (servo_valid)
        begin
            control <= servo_value + control_offset;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            control_valid <= 1'b0;
        end
        else
        begin
            control_valid <= servo_valid;
        end
    end

    // Strobe leaves the core, keep it clean
    assert property (@(posedge aclk) disable iff (!rst_n)
        !$isunknown(control_valid))
        else $error("control_valid is unknown");

endmodule

/* hdl/z_servo_top.sv */
`timescale 1ns/1ps

module z_servo_top
    import z_servo_pkg::*;
(
    input  logic                            aclk,
    input  logic                            rst_n,

    input  logic        [CONFIG_ADDR_W-1:0] config_addr,
    input  logic        [CONFIG_DATA_W-1:0] config_data,
    input  logic        [DATA_W-1:0]        options,

    input  logic signed [DATA_W-1:0]        sample,
    input  logic                            sample_valid,

    output logic signed [DATA_W-1:0]        control,
    output logic                            control_valid
);

    // Configuration levels
    logic signed [DATA_W-1:0] setpoint;
    logic signed [DATA_W-1:0] cp;
    logic signed [DATA_W-1:0] ci;
    logic signed [DATA_W-1:0] upper_bound;
    logic signed [DATA_W-1:0] lower_bound;
    logic signed [DATA_W-1:0] signal_offset;
    logic signed [DATA_W-1:0] control_offset;
    logic signed [DATA_W-1:0] z_reset;
    logic                     servo_enable;
    logic                     servo_hold;

    // Pipeline
    logic signed [DATA_W-1:0] error;
    logic                     error_valid;
    logic signed [DATA_W-1:0] servo_value;
    logic                     servo_valid;

    z_servo_configuration u_configuration (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .config_addr    (config_addr),
        .config_data    (config_data),
        .options        (options),
        .setpoint       (setpoint),
        .cp             (cp),
        .ci             (ci),
        .upper_bound    (upper_bound),
        .lower_bound    (lower_bound),
        .signal_offset  (signal_offset),
        .control_offset (control_offset),
        .z_reset        (z_reset),
        .servo_enable   (servo_enable),
        .servo_hold     (servo_hold)
    );

    z_servo_error_stage u_error_stage (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .signal_offset (signal_offset),
        .setpoint      (setpoint),
        .error         (error),
        .error_valid   (error_valid)
    );

    z_servo_pi_stage u_pi_stage (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .error        (error),
        .error_valid  (error_valid),
        .cp           (cp),
        .ci           (ci),
        .upper_bound  (upper_bound),
        .lower_bound  (lower_bound),
        .z_reset      (z_reset),
        .servo_enable (servo_enable),
        .servo_hold   (servo_hold),
        .servo_value  (servo_value),
        .servo_valid  (servo_valid)
    );

    z_servo_output_stage u_output_stage (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .servo_value    (servo_value),
        .servo_valid    (servo_valid),
        .control_offset (control_offset),
        .control        (control),
        .control_valid  (control_valid)
    );

    // Fixed latency through all four stages
    assert property (@(posedge aclk) disable iff (!rst_n)
        control_valid == $past(sample_valid, PIPE_LATENCY))
        else $error("control_valid does not follow sample_valid by PIPE_LATENCY");

endmodule

/* bench/z_servo_tb.sv */
`timescale 1ns/1ps

module z_servo_tb
    import z_servo_pkg::*;
();

    localparam int CLK_PERIOD    = 4;
    localparam int DRAIN_TIMEOUT = 32;

    logic                            aclk;
    logic                            rst_n;
    logic        [CONFIG_ADDR_W-1:0] config_addr;
    logic        [CONFIG_DATA_W-1:0] config_data;
    logic        [DATA_W-1:0]        options;
    logic signed [DATA_W-1:0]        sample;
    logic                            sample_valid;
    logic signed [DATA_W-1:0]        control;
    logic                            control_valid;

    // Model copy of the register bank and the integrator
    int                m_setpoint;
    int                m_cp;
    int                m_ci;
    int                m_upper;
    int                m_lower;
    int                m_soff;
    int                m_coff;
    int                m_zreset;
    logic [DATA_W-1:0] m_mode;
    logic [DATA_W-1:0] m_options;
    int                m_integrator;
    // DUT control values seen at a bound plus the control offset
    int                clamp_hits;

    // Expected control values and the edge where the DUT took each sample
    int  expected_q[$];
    time stamp_q[$];

    z_servo_top u_z_servo_top (
        .aclk          (aclk),
        .rst_n         (rst_n),
        .config_addr   (config_addr),
        .config_data   (config_data),
        .options       (options),
        .sample        (sample),
        .sample_valid  (sample_valid),
        .control       (control),
        .control_valid (control_valid)
    );

    initial
    begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string name, input logic signed [63:0] expected,
                                 input logic signed [63:0] actual);
        if (actual !== expected)
        begin
            $display("ERR t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic stop_run(input string reason);
        $display("%s at t=%0t", reason, $time);
        $display("Verification failed");
        $fatal(1);
    endtask

    function automatic int saturate(input longint value);
        if (value > longint'(m_upper))
            return m_upper;
        if (value < longint'(m_lower))
            return m_lower;
        return int'(value);
    endfunction

    // Steps the model integrator once per sample
    function automatic int reference_control(input int s);
        int     err;
        int     servo;
        longint p_term;
        longint i_step;
        logic   enable;
        logic   hold;
        enable = m_mode[MODE_ENABLE_BIT];
        hold   = m_mode[MODE_HOLD_BIT] | m_options[OPTION_HOLD_BIT];
        err    = s - m_soff - m_setpoint;
        p_term = (longint'(m_cp) * longint'(err)) >>> GAIN_FRAC_BITS;
        i_step = (longint'(m_ci) * longint'(err)) >>> GAIN_FRAC_BITS;
        if (!enable)
            m_integrator = m_zreset;
        else if (!hold)
            m_integrator = saturate(longint'(m_integrator) + i_step);
        if (!enable)
        begin
            servo = m_zreset;
        end
        else
        begin
            servo = saturate(longint'(m_integrator) + p_term);
        end
        return servo + m_coff;
    endfunction

    // Scoreboard reads registered outputs at the clock edge
    always @(posedge aclk)
    begin : compare_outputs
        int  exp_control;
        time stamp;
        if (rst_n && control_valid)
        begin
            if (expected_q.size() == 0)
            begin
                stop_run("control_valid arrived with no sample in flight");
            end
            else
            begin
                exp_control = expected_q.pop_front();
                stamp       = stamp_q.pop_front();
                compare_value("control_valid latency", PIPE_LATENCY,
                              ($time - stamp) / CLK_PERIOD);
                compare_value("control", exp_control, control);
                if (control == m_upper + m_coff || control == m_lower + m_coff)
                    clamp_hits++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////////////////////

    function automatic int rand_signed(input int span);
        return int'($urandom_range(0, 2 * span)) - span;
    endfunction

    task automatic write_config(input logic [CONFIG_ADDR_W-1:0] addr,
                                input logic [CONFIG_DATA_W-1:0] data);
        @(posedge aclk);
        sample_valid <= 1'b0;
        config_addr  <= addr;
        config_data  <= data;
        @(posedge aclk);
        config_addr  <= '0;
        @(posedge aclk);
    endtask

    task automatic write_control(input int sp, input int kp, input int ki,
                                 input int hi, input int lo);
        logic [CONFIG_DATA_W-1:0] data;
        data = '0;
        data[0*DATA_W +: DATA_W] = sp;
        data[1*DATA_W +: DATA_W] = kp;
        data[2*DATA_W +: DATA_W] = ki;
        data[3*DATA_W +: DATA_W] = hi;
        data[4*DATA_W +: DATA_W] = lo;
        write_config(CONTROL_REG_ADDR, data);
        m_setpoint = sp;
        m_cp       = kp;
        m_ci       = ki;
        m_upper    = hi;
        m_lower    = lo;
    endtask

    task automatic write_modes(input int soff, input int coff, input int zres,
                               input logic [DATA_W-1:0] mode);
        logic [CONFIG_DATA_W-1:0] data;
        data = '0;
        data[0*DATA_W +: DATA_W] = soff;
        data[1*DATA_W +: DATA_W] = coff;
        data[2*DATA_W +: DATA_W] = zres;
        data[3*DATA_W +: DATA_W] = mode;
        write_config(MODES_REG_ADDR, data);
        m_soff   = soff;
        m_coff   = coff;
        m_zreset = zres;
        m_mode   = mode;
    endtask

    // Options pass a one cycle buffer before they reach the servo
    task automatic set_options(input logic [DATA_W-1:0] value);
        @(posedge aclk);
        sample_valid <= 1'b0;
        options      <= value;
        m_options     = value;
        repeat (2) @(posedge aclk);
    endtask

    task automatic send_sample(input int s);
        @(posedge aclk);
        sample       <= s;
        sample_valid <= 1'b1;
        expected_q.push_back(reference_control(s));
        stamp_q.push_back($time + CLK_PERIOD);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge aclk);
            sample_valid <= 1'b0;
        end
    endtask

    // Mix of back to back and spaced samples
    task automatic send_burst(input int count, input int span);
        for (int i = 0; i < count; i++)
        begin
            send_sample(rand_signed(span));
            if ($urandom_range(0, 3) == 0)
                idle($urandom_range(1, 2));
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        idle(1);
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT)
        begin
            @(posedge aclk);
            cycles++;
        end
        if (expected_q.size() != 0)
            stop_run("Timeout waiting for control_valid");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [CONFIG_DATA_W-1:0] junk;
        int                       seed_value;
        seed_value   = $urandom(90272);
        rst_n        = 1'b0;
        config_addr  = '0;
        config_data  = '0;
        options      = '0;
        sample       = '0;
        sample_valid = 1'b0;
        {m_setpoint, m_cp, m_ci, m_upper, m_lower} = '0;
        {m_soff, m_coff, m_zreset, m_integrator, clamp_hits} = '0;
        m_mode       = '0;
        m_options    = '0;
        repeat (2) @(posedge aclk);
        rst_n <= 1'b1;

        // Quiet after reset and then one sample with everything zero
        repeat (10)
        begin
            @(posedge aclk);
            compare_value("control_valid", 0, control_valid);
        end
        send_sample(rand_signed(1 << 20));
        wait_drain();

        // With enable clear the output follows z reset plus control offset
        write_modes(rand_signed(1 << 16), rand_signed(1 << 16), rand_signed(1 << 20), '0);
        send_burst(12, 1 << 20);
        wait_drain();

        // Enable set with wide bounds so the model integrator must track
        write_control(rand_signed(1 << 16), rand_signed(1 << 15), rand_signed(1 << 13),
                      1 << 28, -(1 << 28));
        write_modes(rand_signed(1 << 16), rand_signed(1 << 16), rand_signed(1 << 20),
                    32'(1) << MODE_ENABLE_BIT);
        send_burst(40, 1 << 20);
        wait_drain();

        // Gains of 16.0 push at least one sample of every pair into a bound
        clamp_hits = 0;
        write_control(0, 32'sd1048576, 32'sd1048576, 1000, -1000);
        for (int i = 0; i < 16; i++)
            send_sample((i % 2 == 0) ? 50000 + rand_signed(1000) : -50000 + rand_signed(1000));
        wait_drain();
        compare_value("saturated control count at least 8", 1, clamp_hits >= 8);

        // Hold through the mode bit, release, then hold through options
        write_control(rand_signed(1 << 16), rand_signed(1 << 15), rand_signed(1 << 13),
                      1 << 28, -(1 << 28));
        send_burst(8, 1 << 20);
        wait_drain();
        write_modes(m_soff, m_coff, m_zreset,
                    (32'(1) << MODE_ENABLE_BIT) | (32'(1) << MODE_HOLD_BIT));
        send_burst(8, 1 << 20);
        wait_drain();
        write_modes(m_soff, m_coff, m_zreset, 32'(1) << MODE_ENABLE_BIT);
        send_burst(8, 1 << 20);
        wait_drain();
        set_options(32'(1) << OPTION_HOLD_BIT);
        send_burst(8, 1 << 20);
        wait_drain();
        set_options('0);
        send_burst(8, 1 << 20);
        wait_drain();

        // Unused address leaves the bank alone
        for (int w = 0; w < CONFIG_DATA_W / 32; w++)
            junk[w*32 +: 32] = $urandom();
        write_config(32'd102, junk);
        send_burst(12, 1 << 20);
        wait_drain();

        repeat (4) @(posedge aclk);
        $display("Verification passed");
        $finish;
    end

    // Cycle limit for the whole run
    initial
    begin
        repeat (20000) @(posedge aclk);
        stop_run("Simulation ran past its cycle limit");
    end

endmodule

/* verilog.f */
hdl/z_servo_pkg.sv
hdl/z_servo_configuration.sv
hdl/z_servo_error_stage.sv
hdl/z_servo_pi_stage.sv
hdl/z_servo_output_stage.sv
hdl/z_servo_top.sv
bench/z_servo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the Z servo testbench with Verilator and run it.
# $fatal in the testbench gives a nonzero exit status.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module z_servo_tb \
    -f verilog.f \
    -o z_servo_sim

./obj_dir/z_servo_sim
